// ==== bench/conv_acc_props.sv ====
`timescale 1ns/1ps

module conv_acc_props (
  input logic clk,
  input logic rst,
  input logic ack_i,
  input logic cyc_i,
  input logic stb_i,
  input logic in_engine_i,
  input logic sram_cs_i,
  input logic sram_we_i,
  input logic eng_active_i,
  input logic host_active_i
);

  ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    ack_i |-> (cyc_i && stb_i))
    else $error("Wishbone ack seen outside an active cycle");

  no_write_in_engine: assert property (@(posedge clk) disable iff (rst)
    in_engine_i |-> !(sram_cs_i && sram_we_i))
    else $error("SRAM write while the engine owns the buffer");

  one_sram_master: assert property (@(posedge clk) disable iff (rst)
    !(eng_active_i && host_active_i))
    else $error("Engine and host both drive the SRAM");

endmodule

// ==== bench/conv_acc_tb.sv ====
`timescale 1ns/1ps
`include "conv_acc_macros.svh"

module conv_acc_tb;

  logic                  clk;
  logic                  rst;
  conv_acc_pkg::wb_req_t wb_req;
  conv_acc_pkg::wb_rsp_t wb_rsp;
  logic [31:0]           shadow [1024];
  int                    errors;
  int                    timeouts;
  int                    seed;

  conv_acc_top dut0 (.clk(clk), .rst(rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp));

  bind wb_host_port conv_acc_props port_props (
    .clk(clk), .rst(rst), .ack_i(wb_rsp_o.ack), .cyc_i(wb_req_i.cyc), .stb_i(wb_req_i.stb),
    .in_engine_i(1'b0), .sram_cs_i(1'b0), .sram_we_i(1'b0),
    .eng_active_i(1'b0), .host_active_i(1'b0)
  );

  bind weight_buffer_wrapper conv_acc_props wrapper_props (
    .clk(clk), .rst(rst), .ack_i(1'b0), .cyc_i(1'b0), .stb_i(1'b0),
    .in_engine_i(state_q == ENGINE), .sram_cs_i(sram_req_o.cs), .sram_we_i(sram_req_o.we),
    .eng_active_i(eng_req_i.cs), .host_active_i(host_own)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic end_run();
    $display("Closing counts: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  function automatic logic [19:0] reg_adr(input logic [7:0] off);
    return {12'h000, off};
  endfunction

  function automatic logic [19:0] weight_adr(input int w);
    logic [19:0] a;
    a = '0;
    a[`CA_REGION_BIT] = 1'b1;
    a[11:2] = w[9:0];
    return a;
  endfunction

  // Reference dot product over the shadow copy with 32-bit wraparound
  function automatic logic [31:0] dot_ref(input int n, input logic [31:0] act);
    logic [31:0] sum;
    int          prod;
    sum = '0;
    for (int w = 0; w < n; w++) begin
      for (int l = 0; l < 4; l++) begin
        prod = int'($signed(shadow[w][8*l +: 8])) * int'($signed(act[8*l +: 8]));
        sum = sum + prod;
      end
    end
    return sum;
  endfunction

  // Holds the request until ack, then releases it after the next edge
  task automatic bus_cycle(input logic we, input logic [19:0] adr, input logic [31:0] wdat,
                           input int limit, output logic [31:0] rdat, output int cycles);
    @(posedge clk);
    #2;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    cycles = 0;
    do begin
      @(posedge clk);
      #2;
      cycles++;
    end while (!wb_rsp.ack && cycles < limit);
    rdat = wb_rsp.dat;
    if (wb_rsp.ack) begin
      @(posedge clk);
      #2;
      wb_req = '0;
    end else begin
      timeouts++;
      $display("Timeout: no Wishbone ack within %0d cycles at address 0x%05h", limit, adr);
      end_run();
    end
  endtask

  task automatic wb_write(input logic [19:0] adr, input logic [31:0] data, output int cycles);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, 2000, unused, cycles);
  endtask

  task automatic wb_read(input logic [19:0] adr, output logic [31:0] data, output int cycles);
    bus_cycle(1'b0, adr, '0, 2000, data, cycles);
  endtask

  task automatic load_weight(input int w, input logic [31:0] data);
    int cycles;
    shadow[w] = data;
    wb_write(weight_adr(w), data, cycles);
  endtask

  task automatic start_run(input int len, input logic [31:0] act);
    int cycles;
    wb_write(reg_adr(`CA_REG_LEN), len, cycles);
    wb_write(reg_adr(`CA_REG_ACT), act, cycles);
    wb_write(reg_adr(`CA_REG_CTRL), 32'h1, cycles);
  endtask

  task automatic wait_done(input string what);
    logic [31:0] status;
    int          polls;
    int          cycles;
    polls  = 0;
    status = '0;
    while (!status[1] && polls < 1000) begin
      wb_read(reg_adr(`CA_REG_STATUS), status, cycles);
      polls++;
    end
    if (!status[1]) begin
      timeouts++;
      $display("Timeout: done never set in STATUS during %s", what);
      end_run();
    end
  endtask

  task automatic check_result(input string what, input int len, input logic [31:0] act);
    logic [31:0] data;
    int          cycles;
    wb_read(reg_adr(`CA_REG_RESULT), data, cycles);
    check_eq(what, data, dot_ref(len, act));
  endtask

  task automatic weight_readback();
    int          addr [16];
    logic [31:0] data;
    int          cycles;
    for (int i = 0; i < 16; i++) begin
      addr[i] = $urandom_range(1023, 0);
      shadow[addr[i]] = $urandom;
      wb_write(weight_adr(addr[i]), shadow[addr[i]], cycles);
      check_eq("weight write latency", cycles, 2);
    end
    for (int i = 0; i < 16; i++) begin
      wb_read(weight_adr(addr[i]), data, cycles);
      check_eq("weight readback", data, shadow[addr[i]]);
      check_eq("weight read latency", cycles, 3);
    end
  endtask

  task automatic register_access();
    logic [31:0] act;
    logic [31:0] data;
    int          cycles;
    act = $urandom;
    wb_read(reg_adr(`CA_REG_STATUS), data, cycles);
    check_eq("STATUS after reset", data, 32'h0);
    check_eq("register read latency", cycles, 1);
    wb_write(reg_adr(`CA_REG_LEN), 32'd777, cycles);
    check_eq("register write latency", cycles, 1);
    wb_write(reg_adr(`CA_REG_ACT), act, cycles);
    wb_read(reg_adr(`CA_REG_LEN), data, cycles);
    check_eq("LEN readback", data, 32'd777);
    wb_read(reg_adr(`CA_REG_ACT), data, cycles);
    check_eq("ACT readback", data, act);
  endtask

  task automatic single_run();
    logic [31:0] act;
    logic [31:0] data;
    int          cycles;
    act = $urandom;
    for (int w = 0; w < 8; w++) begin
      load_weight(w, $urandom);
    end
    start_run(8, act);
    wait_done("single run");
    check_result("RESULT of 8-word run", 8, act);
    wb_read(reg_adr(`CA_REG_STATUS), data, cycles);
    check_eq("STATUS after run", data, 32'h2);
  endtask

  task automatic signed_extremes();
    load_weight(0, 32'h8080_8080);
    load_weight(1, 32'h7F7F_7F7F);
    load_weight(2, 32'h807F_7F80);
    load_weight(3, 32'h7F80_807F);
    start_run(4, 32'h8080_8080);
    wait_done("signed extremes");
    check_result("RESULT of signed extremes", 4, 32'h8080_8080);
  endtask

  task automatic host_access_during_run();
    logic [31:0] act;
    logic [31:0] data;
    int          cycles;
    act = $urandom;
    for (int w = 0; w < 1024; w++) begin
      load_weight(w, (w * 32'h9E37_79B1) ^ (w << 11) ^ 32'h5A5A_0000);
    end
    start_run(1024, act);
    wb_read(weight_adr(717), data, cycles);
    check_eq("weight read during run", data, shadow[717]);
    check_eq("engine busy at host ack", dut0.busy, 32'h0);
    // The engine streams 1024 reads before the host can get in
    assert (cycles > 1024) else begin
      errors++;
      $display("MISMATCH at %0t: host read acked after %0d cycles, inside the run", $time,
               cycles);
    end
    wait_done("long run");
    check_result("RESULT of 1024-word run", 1024, act);
  endtask

  task automatic restart_run();
    logic [31:0] act;
    logic [31:0] data;
    int          cycles;
    act = $urandom;
    start_run(300, act);
    wb_read(reg_adr(`CA_REG_STATUS), data, cycles);
    check_eq("STATUS right after restart", data, 32'h1);
    wait_done("restart");
    check_result("RESULT after restart", 300, act);
  endtask

  initial begin
    errors   = 0;
    timeouts = 0;
    seed     = $urandom(94);
    rst      = 1'b1;
    wb_req   = '0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    weight_readback();
    register_access();
    single_run();
    signed_extremes();
    host_access_during_run();
    restart_run();
    end_run();
  end

endmodule

// ==== common/conv_acc_macros.svh ====
`ifndef CONV_ACC_MACROS_SVH
`define CONV_ACC_MACROS_SVH

// Datapath and bus widths
`define CA_DATA_W 32
`define CA_WB_ADR_W 20

// Weight SRAM geometry
`define CA_WEIGHT_DEPTH 1024
`define CA_WEIGHT_AW 10

// Byte address bit that selects the weight region over the registers
`define CA_REGION_BIT 16

// Register byte offsets decoded from adr[7:0]
`define CA_REG_CTRL 8'h00
`define CA_REG_LEN 8'h04
`define CA_REG_ACT 8'h08
`define CA_REG_STATUS 8'h0C
`define CA_REG_RESULT 8'h10

`endif

// ==== common/conv_acc_pkg.sv ====
`include "conv_acc_macros.svh"

package conv_acc_pkg;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`CA_WB_ADR_W-1:0] adr;
    logic [`CA_DATA_W-1:0]   dat;
  } wb_req_t;

  typedef struct packed {
    logic [`CA_DATA_W-1:0] dat;
    logic                  ack;
  } wb_rsp_t;

  // Host weight access already reduced to a word address
  typedef struct packed {
    logic                     valid;
    logic                     we;
    logic [`CA_WEIGHT_AW-1:0] addr;
    logic [`CA_DATA_W-1:0]    wdata;
  } buf_req_t;

  typedef struct packed {
    logic                  ack;
    logic [`CA_DATA_W-1:0] rdata;
  } buf_rsp_t;

  typedef struct packed {
    logic                     cs;
    logic                     we;
    logic [`CA_WEIGHT_AW-1:0] addr;
    logic [`CA_DATA_W-1:0]    wdata;
  } sram_req_t;

  // Raw word for host and SRAM, four int8 lanes for the engine (lane 0 = low byte)
  typedef union packed {
    logic [`CA_DATA_W-1:0] raw;
    logic [3:0][7:0]       lane;
  } weight_word_u;

endpackage

// ==== source/conv_acc_top.sv ====
`timescale 1ns/1ps
`include "conv_acc_macros.svh"

module conv_acc_top (
  input  logic                  clk,
  input  logic                  rst,
  input  conv_acc_pkg::wb_req_t wb_req_i,
  output conv_acc_pkg::wb_rsp_t wb_rsp_o
);

  conv_acc_pkg::buf_req_t     buf_req;
  conv_acc_pkg::buf_rsp_t     buf_rsp;
  conv_acc_pkg::sram_req_t    eng_req;
  conv_acc_pkg::sram_req_t    sram_req;
  conv_acc_pkg::weight_word_u eng_rdata;
  conv_acc_pkg::weight_word_u act;
  logic [`CA_DATA_W-1:0]      sram_rdata;
  logic [`CA_DATA_W-1:0]      result;
  logic [`CA_WEIGHT_AW:0]     len;
  logic                       start;
  logic                       busy;
  logic                       done;

  wb_host_port u_port (
    .clk(clk), .rst(rst),
    .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
    .buf_req_o(buf_req), .buf_rsp_i(buf_rsp),
    .start_o(start), .len_o(len), .act_o(act),
    .busy_i(busy), .done_i(done), .result_i(result)
  );

  weight_buffer_wrapper u_wrapper (
    .clk(clk), .rst(rst),
    .host_req_i(buf_req), .host_rsp_o(buf_rsp),
    .eng_busy_i(busy), .eng_req_i(eng_req), .eng_rdata_o(eng_rdata),
    .sram_req_o(sram_req), .sram_rdata_i(sram_rdata)
  );

  weight_sram u_sram (.clk(clk), .req_i(sram_req), .rdata_o(sram_rdata));

  dot_product_engine u_engine (
    .clk(clk), .rst(rst),
    .start_i(start), .len_i(len), .act_i(act),
    .busy_o(busy), .done_o(done), .result_o(result),
    .sram_req_o(eng_req), .rdata_i(eng_rdata)
  );

endmodule

// ==== source/dot_product_engine.sv ====
`timescale 1ns/1ps
`include "conv_acc_macros.svh"

module dot_product_engine (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_i,
  input  logic [`CA_WEIGHT_AW:0]     len_i,
  input  conv_acc_pkg::weight_word_u act_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic [`CA_DATA_W-1:0]      result_o,
  output conv_acc_pkg::sram_req_t    sram_req_o,
  input  conv_acc_pkg::weight_word_u rdata_i
);

  logic                         busy_q;
  logic                         done_q;
  logic                         issue_q;
  logic [`CA_WEIGHT_AW:0]       cnt_q;
  logic [`CA_WEIGHT_AW:0]       len_q;
  conv_acc_pkg::weight_word_u   act_q;
  logic                         last_issue;
  // Pipeline valids and last tags for the read in flight and the product sum
  logic                         rd_v_q;
  logic                         rd_last_q;
  logic                         prod_v_q;
  logic                         prod_last_q;
  logic signed [15:0]           prod [4];
  logic signed [`CA_DATA_W-1:0] lane_sum;
  logic signed [`CA_DATA_W-1:0] prod_sum_q;
  logic signed [`CA_DATA_W-1:0] acc_q;
  logic                         launch;

  assign launch     = start_i && !busy_q;
  assign last_issue = issue_q && (cnt_q == len_q - 1'b1);

  always_comb begin
    lane_sum = '0;
    for (int i = 0; i < 4; i++) begin
      prod[i]  = $signed(rdata_i.lane[i]) * $signed(act_q.lane[i]);
      lane_sum = lane_sum + prod[i];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      issue_q     <= 1'b0;
      cnt_q       <= '0;
      rd_v_q      <= 1'b0;
      rd_last_q   <= 1'b0;
      prod_v_q    <= 1'b0;
      prod_last_q <= 1'b0;
      acc_q       <= '0;
    end else begin
      done_q      <= 1'b0;
      rd_v_q      <= issue_q;
      rd_last_q   <= last_issue;
      prod_v_q    <= rd_v_q;
      prod_last_q <= rd_last_q;
      if (launch) begin
        busy_q  <= 1'b1;
        issue_q <= 1'b1;
        cnt_q   <= '0;
        acc_q   <= '0;
      end else begin
        if (issue_q) begin
          cnt_q <= cnt_q + 1'b1;
        end
        if (last_issue) begin
          issue_q <= 1'b0;
        end
        if (prod_v_q) begin
          acc_q <= acc_q + prod_sum_q;
        end
        if (prod_last_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Run operands are frozen at start
  always_ff @(posedge clk) begin
    if (launch) begin
      len_q <= len_i;
      act_q <= act_i;
    end
    if (rd_v_q) begin
      prod_sum_q <= lane_sum;
    end
  end

  always_comb begin
    sram_req_o.cs    = issue_q;
    sram_req_o.we    = 1'b0;
    sram_req_o.addr  = cnt_q[`CA_WEIGHT_AW-1:0];
    sram_req_o.wdata = '0;
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign result_o = acc_q;

endmodule

// ==== source/wb_host_port.sv ====
`timescale 1ns/1ps
`include "conv_acc_macros.svh"

module wb_host_port (
  input  logic                       clk,
  input  logic                       rst,
  input  conv_acc_pkg::wb_req_t      wb_req_i,
  output conv_acc_pkg::wb_rsp_t      wb_rsp_o,
  output conv_acc_pkg::buf_req_t     buf_req_o,
  input  conv_acc_pkg::buf_rsp_t     buf_rsp_i,
  output logic                       start_o,
  output logic [`CA_WEIGHT_AW:0]     len_o,
  output conv_acc_pkg::weight_word_u act_o,
  input  logic                       busy_i,
  input  logic                       done_i,
  input  logic [`CA_DATA_W-1:0]      result_i
);

  logic                      ack_q;
  logic [`CA_DATA_W-1:0]     dat_q;
  logic                      start_q;
  logic                      done_q;
  logic [`CA_WEIGHT_AW:0]    len_q;
  conv_acc_pkg::weight_word_u act_q;
  logic                      stb_hit;
  logic                      weight_sel;
  logic [`CA_DATA_W-1:0]     reg_rdata;

  // Active cycle not yet acked
  assign stb_hit    = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign weight_sel = wb_req_i.adr[`CA_REGION_BIT];

  always_comb begin
    buf_req_o.valid = stb_hit && weight_sel;
    buf_req_o.we    = wb_req_i.we;
    buf_req_o.addr  = wb_req_i.adr[`CA_WEIGHT_AW+1:2];
    buf_req_o.wdata = wb_req_i.dat;
  end

  always_comb begin
    case (wb_req_i.adr[7:0])
      `CA_REG_LEN:    reg_rdata = {{(`CA_DATA_W-`CA_WEIGHT_AW-1){1'b0}}, len_q};
      `CA_REG_ACT:    reg_rdata = act_q.raw;
      `CA_REG_STATUS: reg_rdata = {{(`CA_DATA_W-2){1'b0}}, done_q, busy_i};
      `CA_REG_RESULT: reg_rdata = result_i;
      default:        reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q     <= 1'b0;
      start_q   <= 1'b0;
      done_q    <= 1'b0;
      len_q     <= '0;
      act_q.raw <= '0;
    end else begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      if (done_i) begin
        done_q <= 1'b1;
      end
      if (stb_hit) begin
        ack_q <= weight_sel ? buf_rsp_i.ack : 1'b1;
      end
      if (stb_hit && !weight_sel && wb_req_i.we) begin
        case (wb_req_i.adr[7:0])
          `CA_REG_CTRL: begin
            if (wb_req_i.dat[0] && !busy_i) begin
              start_q <= 1'b1;
              done_q  <= 1'b0;
            end
          end
          `CA_REG_LEN: len_q     <= wb_req_i.dat[`CA_WEIGHT_AW:0];
          `CA_REG_ACT: act_q.raw <= wb_req_i.dat;
          default: ;
        endcase
      end
    end
  end

  // Last update before ack carries the final data
  always_ff @(posedge clk) begin
    if (stb_hit) begin
      dat_q <= weight_sel ? buf_rsp_i.rdata : reg_rdata;
    end
  end

  always_comb begin
    wb_rsp_o.dat = dat_q;
    wb_rsp_o.ack = ack_q;
  end

  assign start_o = start_q;
  assign len_o   = len_q;
  assign act_o   = act_q;

endmodule

// ==== sources.f ====
+incdir+common
common/conv_acc_pkg.sv
weight_buffer/weight_sram.sv
weight_buffer/weight_buffer_wrapper.sv
source/wb_host_port.sv
source/dot_product_engine.sv
source/conv_acc_top.sv
bench/conv_acc_props.sv
bench/conv_acc_tb.sv

// ==== weight_buffer/weight_buffer_wrapper.sv ====
`timescale 1ns/1ps
`include "conv_acc_macros.svh"

module weight_buffer_wrapper (
  input  logic                       clk,
  input  logic                       rst,
  input  conv_acc_pkg::buf_req_t     host_req_i,
  output conv_acc_pkg::buf_rsp_t     host_rsp_o,
  input  logic                       eng_busy_i,
  input  conv_acc_pkg::sram_req_t    eng_req_i,
  output conv_acc_pkg::weight_word_u eng_rdata_o,
  output conv_acc_pkg::sram_req_t    sram_req_o,
  input  logic [`CA_DATA_W-1:0]      sram_rdata_i
);

  typedef enum logic [1:0] {
    IDLE    = 2'h0,
    ENGINE  = 2'h1,
    HOST_RD = 2'h2,
    HOST_WR = 2'h3
  } own_state_t;

  own_state_t state_q;
  own_state_t state_d;
  // Second cycle of a host read, when SRAM data is valid
  logic       rd_phase_q;
  logic       eng_own;
  logic       host_own;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= IDLE;
      rd_phase_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_phase_q <= (state_q == HOST_RD) && !rd_phase_q;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Engine wins over a waiting host
        if (eng_busy_i) begin
          state_d = ENGINE;
        end else if (host_req_i.valid) begin
          state_d = host_req_i.we ? HOST_WR : HOST_RD;
        end
      end
      ENGINE: begin
        if (!eng_busy_i) begin
          state_d = IDLE;
        end
      end
      HOST_RD: begin
        if (rd_phase_q) begin
          state_d = IDLE;
        end
      end
      HOST_WR: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // First engine read goes out while the FSM is still leaving IDLE
  assign eng_own  = (state_q == ENGINE) || ((state_q == IDLE) && eng_busy_i);
  assign host_own = (state_q == HOST_WR) || ((state_q == HOST_RD) && !rd_phase_q);

  always_comb begin
    sram_req_o = '0;
    if (eng_own) begin
      sram_req_o = eng_req_i;
    end else if (host_own) begin
      sram_req_o.cs    = 1'b1;
      sram_req_o.we    = (state_q == HOST_WR);
      sram_req_o.addr  = host_req_i.addr;
      sram_req_o.wdata = host_req_i.wdata;
    end
  end

  // Read data only reaches the current owner
  always_comb begin
    host_rsp_o.ack   = (state_q == HOST_WR) || ((state_q == HOST_RD) && rd_phase_q);
    host_rsp_o.rdata = (state_q == HOST_RD) ? sram_rdata_i : '0;
    eng_rdata_o.raw  = (state_q == ENGINE) ? sram_rdata_i : '0;
  end

endmodule

// ==== weight_buffer/weight_sram.sv ====
`timescale 1ns/1ps
`include "conv_acc_macros.svh"

module weight_sram (
  input  logic                    clk,
  input  conv_acc_pkg::sram_req_t req_i,
  output logic [`CA_DATA_W-1:0]   rdata_o
);

  logic [`CA_DATA_W-1:0] mem [`CA_WEIGHT_DEPTH];

  // Single port, registered read
  always_ff @(posedge clk) begin
    if (req_i.cs) begin
      if (req_i.we) begin
        mem[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_o <= mem[req_i.addr];
      end
    end
  end

endmodule
